//--- Makefile
# Verilator build and run of the dual-clock FIFO testbench

VERILATOR ?= verilator
TOP       ?= tb_async_fifo
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN) tb_input.txt
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "run passed"; \
	else \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- async_fifo_top.sv
`timescale 1ns/1ps

module async_fifo_top
    import fifo_geom_pkg::*;
    import fifo_payload_pkg::*;
#(
    parameter type word_t = payload_t
) (
    // write side
    input  logic                  i_wr_clk,
    input  logic                  i_wr_rst_n,
    input  logic                  i_wr_en,
    input  word_t                 i_wr_data,
    output logic                  o_wr_full,
    output logic                  o_wr_almost_full,
    // read side
    input  logic                  i_rd_clk,
    input  logic                  i_rd_rst_n,
    input  logic                  i_rd_en,
    output word_t                 o_rd_data,
    output logic                  o_rd_empty,
    output logic                  o_rd_almost_empty,
    output logic [FIFO_PTR_W-1:0] o_rd_count
);

    // write domain
    logic                   wr_accept;
    logic [FIFO_ADDR_W-1:0] wr_addr;
    logic [FIFO_PTR_W-1:0]  wr_ptr_bin;
    logic [FIFO_PTR_W-1:0]  wr_ptr_gray;
    logic [FIFO_PTR_W-1:0]  rd_ptr_bin_wdom;

    // read domain
    logic                   rd_accept;
    logic [FIFO_ADDR_W-1:0] rd_addr;
    logic [FIFO_PTR_W-1:0]  rd_ptr_bin;
    logic [FIFO_PTR_W-1:0]  rd_ptr_gray;
    logic [FIFO_PTR_W-1:0]  wr_ptr_bin_rdom;

    // ==============================
    // pointer domains
    // ==============================
    wr_ptr_domain u_wr_ptr (
        .i_wr_clk          (i_wr_clk),
        .i_wr_rst_n        (i_wr_rst_n),
        .i_wr_en           (i_wr_en),
        .i_wr_full         (o_wr_full),                 // flag loops back
        .i_rd_ptr_gray     (rd_ptr_gray),
        .o_wr_accept       (wr_accept),
        .o_wr_addr         (wr_addr),
        .o_wr_ptr_bin      (wr_ptr_bin),
        .o_wr_ptr_gray     (wr_ptr_gray),
        .o_rd_ptr_bin_wdom (rd_ptr_bin_wdom)
    );

    rd_ptr_domain u_rd_ptr (
        .i_rd_clk          (i_rd_clk),
        .i_rd_rst_n        (i_rd_rst_n),
        .i_rd_en           (i_rd_en),
        .i_rd_empty        (o_rd_empty),
        .i_wr_ptr_gray     (wr_ptr_gray),
        .o_rd_accept       (rd_accept),
        .o_rd_addr         (rd_addr),
        .o_rd_ptr_bin      (rd_ptr_bin),
        .o_rd_ptr_gray     (rd_ptr_gray),
        .o_wr_ptr_bin_rdom (wr_ptr_bin_rdom)
    );

    // ==============================
    // flags and storage
    // ==============================
    fifo_control u_control (
        .i_wr_clk          (i_wr_clk),
        .i_wr_rst_n        (i_wr_rst_n),
        .i_rd_clk          (i_rd_clk),
        .i_rd_rst_n        (i_rd_rst_n),
        .i_wr_ptr_bin      (wr_ptr_bin),
        .i_wr_rdom_ptr_bin (rd_ptr_bin_wdom),
        .i_rd_ptr_bin      (rd_ptr_bin),
        .i_rd_wdom_ptr_bin (wr_ptr_bin_rdom),
        .o_wr_full         (o_wr_full),
        .o_wr_almost_full  (o_wr_almost_full),
        .o_rd_empty        (o_rd_empty),
        .o_rd_almost_empty (o_rd_almost_empty),
        .o_rd_count        (o_rd_count)
    );

    fifo_storage #(
        .word_t (word_t)
    ) u_storage (
        .i_wr_clk    (i_wr_clk),
        .i_wr_accept (wr_accept),
        .i_wr_addr   (wr_addr),
        .i_wr_data   (i_wr_data),
        .i_rd_clk    (i_rd_clk),
        .i_rd_rst_n  (i_rd_rst_n),
        .i_rd_accept (rd_accept),
        .i_rd_addr   (rd_addr),
        .o_rd_data   (o_rd_data)
    );

endmodule : async_fifo_top

//--- fifo_control.sv
`timescale 1ns/1ps

module fifo_control
    import fifo_geom_pkg::*;
(
    // clocks and resets
    input  logic                  i_wr_clk,
    input  logic                  i_wr_rst_n,
    input  logic                  i_rd_clk,
    input  logic                  i_rd_rst_n,
    // pointers
    input  logic [FIFO_PTR_W-1:0] i_wr_ptr_bin,         // own write pointer
    input  logic [FIFO_PTR_W-1:0] i_wr_rdom_ptr_bin,    // read pointer, wr clock view
    input  logic [FIFO_PTR_W-1:0] i_rd_ptr_bin,         // own read pointer
    input  logic [FIFO_PTR_W-1:0] i_rd_wdom_ptr_bin,    // write pointer, rd clock view
    // flags
    output logic                  o_wr_full,
    output logic                  o_wr_almost_full,
    output logic                  o_rd_empty,
    output logic                  o_rd_almost_empty,
    output logic [FIFO_PTR_W-1:0] o_rd_count
);

    logic                  wr_wrap_diff;
    logic                  rd_wrap_diff;
    logic [FIFO_PTR_W-1:0] wr_fill;
    logic [FIFO_PTR_W-1:0] rd_fill;
    logic                  wr_full_d;
    logic                  wr_almost_full_d;
    logic                  rd_empty_d;
    logic                  rd_almost_empty_d;

    // ==============================
    // wrap bit compare
    // ==============================
    assign wr_wrap_diff = i_wr_ptr_bin[FIFO_ADDR_W] ^ i_wr_rdom_ptr_bin[FIFO_ADDR_W];
    assign rd_wrap_diff = i_rd_ptr_bin[FIFO_ADDR_W] ^ i_rd_wdom_ptr_bin[FIFO_ADDR_W];

    // occupancy, modulo 2*depth by the pointer width itself
    assign wr_fill = i_wr_ptr_bin - i_wr_rdom_ptr_bin;
    assign rd_fill = i_rd_wdom_ptr_bin - i_rd_ptr_bin;

    // ==============================
    // write side flags
    // ==============================
    assign wr_full_d = wr_wrap_diff &&
        (i_wr_ptr_bin[FIFO_ADDR_W-1:0] == i_wr_rdom_ptr_bin[FIFO_ADDR_W-1:0]);
    assign wr_almost_full_d = wr_fill >= FIFO_PTR_W'(FIFO_DEPTH - ALMOST_FULL_MARGIN);

    always_ff @(posedge i_wr_clk or negedge i_wr_rst_n) begin
        if (!i_wr_rst_n) begin
            o_wr_full        <= 1'b0;
            o_wr_almost_full <= 1'b0;
        end else begin
            o_wr_full        <= wr_full_d;
            o_wr_almost_full <= wr_almost_full_d;
        end
    end

    // ==============================
    // read side flags
    // ==============================
    assign rd_empty_d = !rd_wrap_diff &&
        (i_rd_ptr_bin[FIFO_ADDR_W-1:0] == i_rd_wdom_ptr_bin[FIFO_ADDR_W-1:0]);

    // one up to the margin, an empty FIFO is not almost empty
    assign rd_almost_empty_d = (rd_fill != '0) &&
        (rd_fill <= FIFO_PTR_W'(ALMOST_EMPTY_MARGIN));

    always_ff @(posedge i_rd_clk or negedge i_rd_rst_n) begin
        if (!i_rd_rst_n) begin
            o_rd_empty        <= 1'b1;                  // nothing stored yet
            o_rd_almost_empty <= 1'b0;
        end else begin
            o_rd_empty        <= rd_empty_d;
            o_rd_almost_empty <= rd_almost_empty_d;
        end
    end

    assign o_rd_count = rd_fill;                        // 0 .. FIFO_DEPTH, unregistered

endmodule : fifo_control

//--- fifo_geom_pkg.sv
package fifo_geom_pkg;

    // ==============================
    // storage geometry
    // ==============================
    localparam int FIFO_DEPTH  = 16;                    // power of two only
    localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_PTR_W  = FIFO_ADDR_W + 1;       // extra wrap bit

    // flag thresholds, in words
    localparam int ALMOST_FULL_MARGIN  = 2;
    localparam int ALMOST_EMPTY_MARGIN = 2;

    // ==============================
    // pointer encoding
    // ==============================
    function automatic logic [FIFO_PTR_W-1:0] bin_to_gray(
        input logic [FIFO_PTR_W-1:0] bin
    );
        return bin ^ (bin >> 1);
    endfunction

    function automatic logic [FIFO_PTR_W-1:0] gray_to_bin(
        input logic [FIFO_PTR_W-1:0] gray
    );
        logic [FIFO_PTR_W-1:0] bin;
        bin[FIFO_PTR_W-1] = gray[FIFO_PTR_W-1];       // msb passes straight
        for (int i = FIFO_PTR_W - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage : fifo_geom_pkg

//--- fifo_payload_pkg.sv
package fifo_payload_pkg;

    // ==============================
    // default FIFO word
    // ==============================
    localparam int PAYLOAD_W = 16;

    // plain vector, other payloads come in through the type parameter
    typedef logic [PAYLOAD_W-1:0] payload_t;

    // ==============================
    // clock crossing
    // ==============================
    // each Gray pointer passes through this many flops in the far domain.
    // two is the minimum the shift below supports
    localparam int SYNC_STAGES = 2;

endpackage : fifo_payload_pkg

//--- fifo_storage.sv
`timescale 1ns/1ps

module fifo_storage
    import fifo_geom_pkg::*;
    import fifo_payload_pkg::*;
#(
    parameter type word_t = payload_t
) (
    // write port
    input  logic                   i_wr_clk,
    input  logic                   i_wr_accept,
    input  logic [FIFO_ADDR_W-1:0] i_wr_addr,
    input  word_t                  i_wr_data,
    // read port
    input  logic                   i_rd_clk,
    input  logic                   i_rd_rst_n,
    input  logic                   i_rd_accept,
    input  logic [FIFO_ADDR_W-1:0] i_rd_addr,
    output word_t                  o_rd_data
);

    word_t mem [FIFO_DEPTH];                            // plain dual-port array

    // ==============================
    // write port
    // ==============================
    always_ff @(posedge i_wr_clk) begin
        if (i_wr_accept) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // ==============================
    // read port
    // ==============================
    // data register holds its value when no read is accepted
    always_ff @(posedge i_rd_clk or negedge i_rd_rst_n) begin
        if (!i_rd_rst_n) begin
            o_rd_data <= '0;
        end else if (i_rd_accept) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule : fifo_storage

//--- list.f
fifo_geom_pkg.sv
fifo_payload_pkg.sv
wr_ptr_domain.sv
rd_ptr_domain.sv
fifo_control.sv
fifo_storage.sv
async_fifo_top.sv
tb_async_fifo.sv

//--- rd_ptr_domain.sv
`timescale 1ns/1ps

module rd_ptr_domain
    import fifo_geom_pkg::*;
    import fifo_payload_pkg::*;
(
    input  logic                   i_rd_clk,
    input  logic                   i_rd_rst_n,
    input  logic                   i_rd_en,
    input  logic                   i_rd_empty,
    input  logic [FIFO_PTR_W-1:0]  i_wr_ptr_gray,          // write domain, async
    output logic                   o_rd_accept,
    output logic [FIFO_ADDR_W-1:0] o_rd_addr,
    output logic [FIFO_PTR_W-1:0]  o_rd_ptr_bin,
    output logic [FIFO_PTR_W-1:0]  o_rd_ptr_gray,
    output logic [FIFO_PTR_W-1:0]  o_wr_ptr_bin_rdom
);

    logic [FIFO_PTR_W-1:0]                   rd_ptr_bin;
    logic [FIFO_PTR_W-1:0]                   rd_ptr_bin_nxt;
    logic [FIFO_PTR_W-1:0]                   rd_ptr_gray;
    logic [SYNC_STAGES-1:0][FIFO_PTR_W-1:0]  wr_gray_sync;
    logic                                    rd_accept;

    // ==============================
    // read pointer
    // ==============================
    assign rd_accept      = i_rd_en && !i_rd_empty;    // reads while empty are dropped
    assign rd_ptr_bin_nxt = rd_ptr_bin + 1'b1;

    always_ff @(posedge i_rd_clk or negedge i_rd_rst_n) begin
        if (!i_rd_rst_n) begin
            rd_ptr_bin  <= '0;
            rd_ptr_gray <= '0;
        end else if (rd_accept) begin
            rd_ptr_bin  <= rd_ptr_bin_nxt;
            rd_ptr_gray <= bin_to_gray(rd_ptr_bin_nxt);
        end
    end

    // ==============================
    // write pointer into rd clock
    // ==============================
    // the far side may run slower or faster, the synced value only ever
    // lags the true write pointer so empty is never released too early
    always_ff @(posedge i_rd_clk or negedge i_rd_rst_n) begin
        if (!i_rd_rst_n) begin
            wr_gray_sync <= '0;
        end else begin
            wr_gray_sync <= {wr_gray_sync[SYNC_STAGES-2:0], i_wr_ptr_gray};
        end
    end

    assign o_wr_ptr_bin_rdom = gray_to_bin(wr_gray_sync[SYNC_STAGES-1]);

    // ==============================
    // outputs
    // ==============================
    assign o_rd_accept   = rd_accept;
    assign o_rd_addr     = rd_ptr_bin[FIFO_ADDR_W-1:0];   // address into storage
    assign o_rd_ptr_bin  = rd_ptr_bin;
    assign o_rd_ptr_gray = rd_ptr_gray;

endmodule : rd_ptr_domain

//--- tb_async_fifo.sv
`timescale 1ns/1ps

module tb_async_fifo
    import fifo_geom_pkg::*;
    import fifo_payload_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 200;                // per wait in that side's clocks
    localparam int CMD_WORDS      = 128;

    logic                  i_wr_clk;
    logic                  i_wr_rst_n;
    logic                  i_wr_en;
    payload_t              i_wr_data;
    logic                  o_wr_full;
    logic                  o_wr_almost_full;
    logic                  i_rd_clk;
    logic                  i_rd_rst_n;
    logic                  i_rd_en;
    payload_t              o_rd_data;
    logic                  o_rd_empty;
    logic                  o_rd_almost_empty;
    logic [FIFO_PTR_W-1:0] o_rd_count;

    logic [19:0] cmd_mem [CMD_WORDS];                   // opcode nibble + 16-bit argument
    payload_t    model_q [$];                           // scoreboard with the oldest word first
    payload_t    dropped_val;
    payload_t    last_read;
    logic        have_dropped;
    logic [15:0] lfsr_state;
    int          error_count;
    int          timeout_count;
    int          check_count;
    logic        aborted;

    async_fifo_top #(
        .word_t (payload_t)
    ) i_dut (
        .i_wr_clk          (i_wr_clk),
        .i_wr_rst_n        (i_wr_rst_n),
        .i_wr_en           (i_wr_en),
        .i_wr_data         (i_wr_data),
        .o_wr_full         (o_wr_full),
        .o_wr_almost_full  (o_wr_almost_full),
        .i_rd_clk          (i_rd_clk),
        .i_rd_rst_n        (i_rd_rst_n),
        .i_rd_en           (i_rd_en),
        .o_rd_data         (o_rd_data),
        .o_rd_empty        (o_rd_empty),
        .o_rd_almost_empty (o_rd_almost_empty),
        .o_rd_count        (o_rd_count)
    );

    // ==============================
    // clocks
    // ==============================
    initial begin
        i_rd_clk = 1'b0;
        forever #5 i_rd_clk = ~i_rd_clk;                // 10 ns
    end

    initial begin
        i_wr_clk = 1'b0;
        forever #7 i_wr_clk = ~i_wr_clk;                // 14 ns and unrelated to the read clock
    end

    // ==============================
    // helpers
    // ==============================
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hB400;                     // x^16 + x^14 + x^13 + x^11 + 1
        end
        return next;
    endfunction

    task automatic pick_gap(output int cycles);
        int b;
        cycles = 0;
        for (b = 0; b < 2; b++) begin
            cycles     = (cycles << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    // polls o_wr_full on the write clock or o_rd_empty on the read clock
    task automatic wait_flag(input logic wr_side, input logic level, output logic ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < TIMEOUT_CYCLES && !ok; n++) begin
            if (wr_side) begin
                @(negedge i_wr_clk);
                ok = (o_wr_full === level);
            end else begin
                @(negedge i_rd_clk);
                ok = (o_rd_empty === level);
            end
        end
        if (!ok) begin
            $display("timeout: %s did not reach %0b within %0d clocks",
                     wr_side ? "o_wr_full" : "o_rd_empty", level, TIMEOUT_CYCLES);
            timeout_count++;
            aborted = 1'b1;
        end
    endtask

    // ==============================
    // commands
    // ==============================
    task automatic write_word(input payload_t value);
        logic expect_drop;
        logic ok;
        expect_drop = (model_q.size() == FIFO_DEPTH);
        wait_flag(1'b1, expect_drop, ok);               // full only changes by our own writes
        if (ok) begin
            @(posedge i_wr_clk);
            i_wr_en   <= 1'b1;
            i_wr_data <= value;
            @(posedge i_wr_clk);                        // strobe sampled here
            i_wr_en   <= 1'b0;
            @(posedge i_wr_clk);                        // full register catches up
            if (expect_drop) begin
                dropped_val  = value;
                have_dropped = 1'b1;
            end else begin
                model_q.push_back(value);
            end
        end
    endtask

    task automatic read_word(input payload_t file_exp);
        payload_t exp;
        logic     ok;
        assert (model_q.size() != 0) else begin
            $display("data file asks for %0h but the scoreboard is empty", file_exp);
            error_count++;
        end
        if (model_q.size() != 0) begin
            exp = model_q.pop_front();
            assert (exp === file_exp) else begin
                $display("data file expects %0h but the scoreboard holds %0h", file_exp, exp);
                error_count++;
            end
            wait_flag(1'b0, 1'b0, ok);
            if (ok) begin
                @(posedge i_rd_clk);
                i_rd_en <= 1'b1;
                @(posedge i_rd_clk);
                i_rd_en <= 1'b0;
                @(negedge i_rd_clk);                    // data register loaded
                check_value("o_rd_data", 32'(o_rd_data), 32'(exp));
                last_read = exp;
                if (have_dropped) begin
                    check_count++;
                    assert (o_rd_data !== dropped_val) else begin
                        $display("CHECK FAILED at %0t ns: o_rd_data got %0h expected not %0h",
                                 $time, o_rd_data, dropped_val);
                        error_count++;
                    end
                end
                @(posedge i_rd_clk);                    // empty register catches up
            end
        end
    endtask

    task automatic read_while_empty();
        logic ok;
        wait_flag(1'b0, 1'b1, ok);
        if (ok) begin
            @(posedge i_rd_clk);
            i_rd_en <= 1'b1;
            @(posedge i_rd_clk);
            i_rd_en <= 1'b0;
            @(negedge i_rd_clk);
            check_value("o_rd_data", 32'(o_rd_data), 32'(last_read));
            @(negedge i_rd_clk);                        // empty register catches up
            check_value("o_rd_empty", 32'(o_rd_empty), 32'd1);
        end
    endtask

    task automatic settle_and_check(input int file_fill);
        int fill;
        fill = model_q.size();
        assert (file_fill == fill) else begin
            $display("data file expects a fill of %0d but the scoreboard holds %0d",
                     file_fill, fill);
            error_count++;
        end
        repeat (4) @(posedge i_wr_clk);
        repeat (4) @(posedge i_rd_clk);
        @(negedge i_rd_clk);
        check_value("o_rd_count", 32'(o_rd_count), 32'(fill));
        check_value("o_rd_empty", 32'(o_rd_empty), 32'(fill == 0));
        check_value("o_rd_almost_empty", 32'(o_rd_almost_empty),
                    32'(fill >= 1 && fill <= ALMOST_EMPTY_MARGIN));
        check_value("o_wr_full", 32'(o_wr_full), 32'(fill == FIFO_DEPTH));
        check_value("o_wr_almost_full", 32'(o_wr_almost_full),
                    32'(fill >= FIFO_DEPTH - ALMOST_FULL_MARGIN));
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        int          pc;
        int          gap;
        logic [3:0]  op;
        logic [15:0] arg;
        logic        done;
        logic        ok;
        i_wr_rst_n    = 1'b0;
        i_rd_rst_n    = 1'b0;
        i_wr_en       = 1'b0;
        i_rd_en       = 1'b0;
        i_wr_data     = '0;
        dropped_val   = '0;
        last_read     = '0;
        have_dropped  = 1'b0;
        lfsr_state    = 16'd57;
        error_count   = 0;
        timeout_count = 0;
        check_count   = 0;
        aborted       = 1'b0;
        done          = 1'b0;
        $readmemh("tb_input.txt", cmd_mem);

        fork
            begin
                repeat (5) @(posedge i_wr_clk);
                i_wr_rst_n <= 1'b1;
            end
            begin
                repeat (5) @(posedge i_rd_clk);
                i_rd_rst_n <= 1'b1;
            end
        join

        @(negedge i_rd_clk);                            // reset values
        check_value("o_rd_empty", 32'(o_rd_empty), 32'd1);
        check_value("o_rd_almost_empty", 32'(o_rd_almost_empty), 32'd0);
        check_value("o_rd_count", 32'(o_rd_count), 32'd0);
        check_value("o_rd_data", 32'(o_rd_data), 32'd0);
        check_value("o_wr_full", 32'(o_wr_full), 32'd0);
        check_value("o_wr_almost_full", 32'(o_wr_almost_full), 32'd0);

        pc = 0;
        while (!aborted && !done && pc < CMD_WORDS) begin
            op  = cmd_mem[pc][19:16];
            arg = cmd_mem[pc][15:0];
            pc++;
            case (op)
                4'h1: write_word(arg);
                4'h2: read_word(arg);
                4'h3: wait_flag(1'b1, 1'b1, ok);
                4'h4: wait_flag(1'b0, 1'b1, ok);
                4'h5: settle_and_check(int'(arg));
                4'h7: read_while_empty();
                4'hF: done = 1'b1;
                default: begin
                    $display("unknown command %05h at word %0d of tb_input.txt",
                             cmd_mem[pc-1], pc - 1);
                    error_count++;
                    done = 1'b1;
                end
            endcase
            pick_gap(gap);
            repeat (gap) @(posedge i_rd_clk);           // idle spacing of 0 to 3 clocks
        end
        assert (done || aborted) else begin
            $display("command stream ended without its end marker");
            error_count++;
        end

        $display("checks run: %0d, check errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_async_fifo

//--- tb_input.txt
// one command per hex word: top digit is the opcode, low four digits the argument
// 1 write value, 2 read and expect value, 3 wait full, 4 wait empty, 5 settle and check fill, 7 read while empty, F end
50000
1A001 1A002 1A003
50003
2A001 50002
2A002 50001
2A003
40000 50000 70000
// fill up to the depth, almost full from a fill of 14
1B000 1B001 1B002 1B003
1B004 1B005 1B006 1B007
1B008 1B009 1B00A 1B00B
1B00C 5000D
1B00D 5000E
1B00E 1B00F
30000 50010
// one write while full, it must be dropped
1DEAD 50010
// drain in order
2B000 2B001 5000E
2B002 5000D
2B003 2B004 2B005 2B006
2B007 2B008 2B009 2B00A
2B00B 2B00C 2B00D 50002
2B00E 50001
2B00F
40000 50000 70000
// short traffic after the pointers have wrapped
1C001 1C002 50002
2C001 50001
2C002 40000 50000
F0000

//--- wr_ptr_domain.sv
`timescale 1ns/1ps

module wr_ptr_domain
    import fifo_geom_pkg::*;
    import fifo_payload_pkg::*;
(
    input  logic                   i_wr_clk,
    input  logic                   i_wr_rst_n,
    input  logic                   i_wr_en,
    input  logic                   i_wr_full,
    input  logic [FIFO_PTR_W-1:0]  i_rd_ptr_gray,          // read domain, async
    output logic                   o_wr_accept,
    output logic [FIFO_ADDR_W-1:0] o_wr_addr,
    output logic [FIFO_PTR_W-1:0]  o_wr_ptr_bin,
    output logic [FIFO_PTR_W-1:0]  o_wr_ptr_gray,
    output logic [FIFO_PTR_W-1:0]  o_rd_ptr_bin_wdom
);

    logic [FIFO_PTR_W-1:0]                   wr_ptr_bin;
    logic [FIFO_PTR_W-1:0]                   wr_ptr_bin_nxt;
    logic [FIFO_PTR_W-1:0]                   wr_ptr_gray;
    logic [SYNC_STAGES-1:0][FIFO_PTR_W-1:0]  rd_gray_sync;
    logic                                    wr_accept;

    // ==============================
    // write pointer
    // ==============================
    assign wr_accept      = i_wr_en && !i_wr_full;     // writes while full are dropped
    assign wr_ptr_bin_nxt = wr_ptr_bin + 1'b1;

    always_ff @(posedge i_wr_clk or negedge i_wr_rst_n) begin
        if (!i_wr_rst_n) begin
            wr_ptr_bin  <= '0;
            wr_ptr_gray <= '0;
        end else if (wr_accept) begin
            wr_ptr_bin  <= wr_ptr_bin_nxt;
            wr_ptr_gray <= bin_to_gray(wr_ptr_bin_nxt);  // registered, glitch free
        end
    end

    // ==============================
    // read pointer into wr clock
    // ==============================
    // only one bit of the Gray value moves per read, so a sample caught
    // mid-change settles to either the old or the new pointer
    always_ff @(posedge i_wr_clk or negedge i_wr_rst_n) begin
        if (!i_wr_rst_n) begin
            rd_gray_sync <= '0;
        end else begin
            rd_gray_sync <= {rd_gray_sync[SYNC_STAGES-2:0], i_rd_ptr_gray};
        end
    end

    assign o_rd_ptr_bin_wdom = gray_to_bin(rd_gray_sync[SYNC_STAGES-1]);

    // ==============================
    // outputs
    // ==============================
    assign o_wr_accept   = wr_accept;
    assign o_wr_addr     = wr_ptr_bin[FIFO_ADDR_W-1:0];   // wrap bit dropped
    assign o_wr_ptr_bin  = wr_ptr_bin;
    assign o_wr_ptr_gray = wr_ptr_gray;

endmodule : wr_ptr_domain
